// File: filelist.f
source/isa_pkg.sv
source/rob_pkg.sv
source/fetch_seq.sv
source/rob_store.sv
source/commit_unit.sv
source/rob_top.sv
tests/rob_checker.sv
tests/tb_rob_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rob_top -f filelist.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_rob_top > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
echo "simulation passed"
exit 0

// File: tests/tb_rob_top.sv
`timescale 1ns/1ps

module tb_rob_top;
  import isa_pkg::*;
  import rob_pkg::*;

  localparam int DEPTH = 8;
  localparam int TAG_W = $clog2(DEPTH);
  localparam int N_PROG = 12;
  localparam addr_t END_PC = 32'd48;
  localparam int STALL_CYCLES = 30;
  localparam int TIMEOUT = 40 * N_PROG + 200;

  // expected commit actions of one instruction
  typedef struct packed {
    logic       has_reg;
    reg_idx_t   rd;
    word_t      value;
    logic       has_store;
    addr_t      st_addr;
    word_t      st_data;
    logic [1:0] st_len;
    logic       has_pd;
    logic       pd_taken;
    logic       has_flush;
    addr_t      flush_pc;
    addr_t      next_pc;
  } expect_t;

  logic clk;
  logic rst;
  logic fetch_en, fetch_done, decode_en, dec_valid, pred_req, pred_valid, pred_taken;
  word_t fetch_instr, decode_instr;
  addr_t fetch_pc;
  decoded_t dec;
  redirect_t pc_write, flush;
  wb_t exec_wb, mem_wb;
  logic [TAG_W-1:0] exec_tag, mem_tag, commit_tag;
  reg_commit_t reg_commit;
  store_req_t store_req;
  logic store_done;
  pd_update_t pd_update;

  // program table, pc is index times four
  decoded_t prog_dec [N_PROG];
  word_t prog_res [N_PROG];
  addr_t prog_tar [N_PROG];
  logic prog_pred [N_PROG];
  logic [TAG_W-1:0] tag_of [N_PROG];

  int fetch_wait, store_wait, in_idx, alloc_total, fetch_cnt, cycles;
  logic [TAG_W-1:0] next_tag;
  addr_t cur_pc, commit_pc;
  logic wb_en, store_busy;
  int pend_tag [$];
  int pend_idx [$];

  rob_top #(.ROB_DEPTH(DEPTH)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic put(input int i, input opcode_t op, input int rd, input int f3,
                     input word_t imm, input word_t res, input addr_t tar, input logic pred);
    prog_dec[i] = '{opcode: op, rd: reg_idx_t'(rd), func3: func3_t'(f3), imm: imm};
    prog_res[i] = res;
    prog_tar[i] = tar;
    prog_pred[i] = pred;
  endtask

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("Done: errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  // instruction word the fetch model returns for a program slot
  function automatic word_t instr_word(input int i);
    return {prog_dec[i].imm[19:0], prog_dec[i].rd, prog_dec[i].opcode};
  endfunction

  // pc the fetch unit is told after an instruction leaves the sequencer
  function automatic addr_t fetch_next(input int i);
    addr_t pc;
    pc = addr_t'(i) << 2;
    if (prog_dec[i].opcode == BRANCH) begin
      return prog_pred[i] ? pc + prog_dec[i].imm : pc + 32'd4;
    end
    if (prog_dec[i].opcode == JAL) begin
      return pc + prog_dec[i].imm;
    end
    return pc + 32'd4;
  endfunction

  function automatic expect_t expected_commit(input int i);
    expect_t e;
    decoded_t d;
    addr_t pc;
    addr_t tgt;
    e = '0;
    d = prog_dec[i];
    pc = addr_t'(i) << 2;
    e.rd = d.rd;
    e.value = prog_res[i];
    e.next_pc = pc + 32'd4;
    case (d.opcode)
      STORE: begin
        e.has_store = 1'b1;
        e.st_addr = prog_tar[i];
        e.st_data = prog_res[i];
        // sb, sh, sw by the low func3 bits
        case (d.func3[1:0])
          2'd0: e.st_len = 2'd0;
          2'd1: e.st_len = 2'd1;
          default: e.st_len = 2'd3;
        endcase
      end
      BRANCH: begin
        tgt = prog_res[i][0] ? pc + d.imm : pc + 32'd4;
        e.has_pd = 1'b1;
        e.pd_taken = prog_res[i][0];
        e.has_flush = prog_res[i][0] != prog_pred[i];
        e.flush_pc = tgt;
        e.next_pc = tgt;
      end
      JALR: begin
        e.has_reg = d.rd != 5'd0;
        e.has_flush = 1'b1;
        e.flush_pc = prog_tar[i];
        e.next_pc = prog_tar[i];
      end
      JAL: begin
        e.has_reg = d.rd != 5'd0;
        e.next_pc = pc + d.imm;
      end
      default: e.has_reg = d.rd != 5'd0;
    endcase
    return e;
  endfunction

  // fetch, decode, predict, writeback and store responders
  always @(posedge clk) begin
    int k;
    fetch_done <= 1'b0;
    dec_valid <= 1'b0;
    pred_valid <= 1'b0;
    exec_wb <= '0;
    mem_wb <= '0;
    store_done <= 1'b0;
    if (rst) begin
      fetch_wait = 0;
      store_wait = 0;
      cur_pc = '0;
      next_tag = '0;
      alloc_total = 0;
      fetch_cnt = 0;
    end else if (flush.valid) begin
      // abandon the in-flight instruction and restart tag counting
      fetch_wait = 0;
      cur_pc = flush.pc;
      next_tag = '0;
      pend_tag.delete();
      pend_idx.delete();
    end else begin
      if (fetch_en) begin
        fetch_cnt++;
        fetch_wait = 1 + int'($urandom % 3);
      end
      if (fetch_wait > 0) begin
        fetch_wait--;
        if (fetch_wait == 0 && cur_pc < END_PC) begin
          in_idx = int'(cur_pc >> 2);
          fetch_done <= 1'b1;
          fetch_pc <= cur_pc;
          fetch_instr <= instr_word(in_idx);
        end
      end
      if (decode_en) begin
        check("decode_instr", decode_instr, instr_word(in_idx));
        dec_valid <= 1'b1;
        dec <= prog_dec[in_idx];
      end
      if (pred_req) begin
        pred_valid <= 1'b1;
        pred_taken <= prog_pred[in_idx];
      end
      if (pc_write.valid) begin
        check("pc_write.pc", pc_write.pc, fetch_next(in_idx));
        tag_of[in_idx] = next_tag;
        pend_tag.push_back(int'(next_tag));
        pend_idx.push_back(in_idx);
        next_tag = next_tag + 1'b1;
        alloc_total++;
        cur_pc = pc_write.pc;
      end
      if (wb_en && pend_tag.size() > 0 && $urandom % 2 == 0) begin
        k = int'($urandom % pend_tag.size());
        if ($urandom % 2 == 0) begin
          exec_wb <= '{valid: 1'b1, result: prog_res[pend_idx[k]], tar_valid: 1'b1,
                       tar_addr: prog_tar[pend_idx[k]]};
          exec_tag <= TAG_W'(pend_tag[k]);
        end else begin
          mem_wb <= '{valid: 1'b1, result: prog_res[pend_idx[k]], tar_valid: 1'b1,
                      tar_addr: prog_tar[pend_idx[k]]};
          mem_tag <= TAG_W'(pend_tag[k]);
        end
        pend_tag.delete(k);
        pend_idx.delete(k);
      end
    end
    if (!rst && store_req.valid) begin
      store_wait = 1 + int'($urandom % 4);
    end else if (store_wait > 0) begin
      store_wait--;
      if (store_wait == 0) begin
        store_done <= 1'b1;
      end
    end
  end

  // compare commit outputs against the program path
  always @(posedge clk) begin
    expect_t e;
    int i;
    if (rst) begin
      commit_pc = '0;
      store_busy = 1'b0;
    end else begin
      if (store_busy && store_done) begin
        store_busy = 1'b0;
      end
      if (reg_commit.valid || store_req.valid || pd_update.valid || flush.valid) begin
        if (store_busy) begin
          fail_now("commit output seen while a store was still outstanding");
        end
        if (commit_pc >= END_PC) begin
          fail_now("commit output seen after the last program instruction");
        end
        i = int'(commit_pc >> 2);
        e = expected_commit(i);
        // instructions with no visible commit action
        while (!e.has_reg && !e.has_store && !e.has_pd && !e.has_flush) begin
          commit_pc = e.next_pc;
          i = int'(commit_pc >> 2);
          e = expected_commit(i);
        end
        check("reg_commit.valid", reg_commit.valid, e.has_reg);
        check("store_req.valid", store_req.valid, e.has_store);
        check("pd_update.valid", pd_update.valid, e.has_pd);
        check("flush.valid", flush.valid, e.has_flush);
        if (e.has_reg) begin
          check("reg_commit.rd", reg_commit.rd, e.rd);
          check("reg_commit.value", reg_commit.value, e.value);
          check("commit_tag", commit_tag, tag_of[i]);
        end
        if (e.has_store) begin
          check("store_req.addr", store_req.addr, e.st_addr);
          check("store_req.data", store_req.data, e.st_data);
          check("store_req.len", store_req.len, e.st_len);
          store_busy = 1'b1;
        end
        if (e.has_pd) begin
          check("pd_update.taken", pd_update.taken, e.pd_taken);
        end
        if (e.has_flush) begin
          check("flush.pc", flush.pc, e.flush_pc);
        end
        commit_pc = e.next_pc;
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, program did not finish", cycles);
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(32'h8b36));
    rst = 1'b1;
    wb_en = 1'b0;
    fetch_done = 1'b0;
    fetch_instr = '0;
    fetch_pc = '0;
    dec_valid = 1'b0;
    dec = '0;
    pred_valid = 1'b0;
    pred_taken = 1'b0;
    exec_wb = '0;
    exec_tag = '0;
    mem_wb = '0;
    mem_tag = '0;
    store_done = 1'b0;
    put(0, OP, 1, 0, 0, 32'h11, 0, 0);
    put(1, OP_IMM, 2, 0, 0, 32'h22, 0, 0);
    put(2, STORE, 0, 2, 0, 32'hdead_beef, 32'h100, 0);
    put(3, OP, 0, 0, 0, 32'h5, 0, 0);
    put(4, BRANCH, 0, 0, 8, 32'h0, 0, 0);
    put(5, BRANCH, 0, 1, 8, 32'h1, 0, 1);
    put(6, OP, 6, 0, 0, 32'h66, 0, 0);
    put(7, STORE, 0, 0, 0, 32'hab, 32'h104, 0);
    put(8, BRANCH, 0, 0, 8, 32'h1, 0, 0);
    put(9, LOAD, 9, 2, 0, 32'h99, 32'h200, 0);
    put(10, JALR, 10, 0, 0, 32'h30, 32'h2c, 0);
    put(11, JAL, 11, 0, 12, 32'h34, 0, 0);
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // no writebacks yet, so the queue must stop one short of full
    while (alloc_total < DEPTH - 1) begin
      @(posedge clk);
    end
    repeat (STALL_CYCLES) @(posedge clk);
    check("alloc_total", alloc_total, DEPTH - 1);
    // every fetch so far completed into one allocation
    check("fetch_en count", fetch_cnt, DEPTH - 1);
    wb_en <= 1'b1;
    while (commit_pc < END_PC) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk);
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: tests/rob_checker.sv
`timescale 1ns/1ps

module rob_checker (
  input logic                clk,
  input logic                rst,
  input logic                fetch_en,
  input logic                decode_en,
  input logic                pred_req,
  input rob_pkg::redirect_t  pc_write,
  input rob_pkg::reg_commit_t reg_commit,
  input rob_pkg::store_req_t store_req,
  input logic                store_done,
  input rob_pkg::pd_update_t pd_update,
  input rob_pkg::redirect_t  flush
);

  logic store_open;

  // a store is open from its request until memory answers
  always_ff @(posedge clk) begin
    if (rst || store_done) begin
      store_open <= 1'b0;
    end else if (store_req.valid) begin
      store_open <= 1'b1;
    end
  end

  a_fetch_en_pulse: assert property (@(posedge clk) disable iff (rst)
    fetch_en |=> !fetch_en) else $error("fetch_en held longer than one cycle");
  a_decode_en_pulse: assert property (@(posedge clk) disable iff (rst)
    decode_en |=> !decode_en) else $error("decode_en held longer than one cycle");
  a_pred_req_pulse: assert property (@(posedge clk) disable iff (rst)
    pred_req |=> !pred_req) else $error("pred_req held longer than one cycle");
  a_pc_write_pulse: assert property (@(posedge clk) disable iff (rst)
    pc_write.valid |=> !pc_write.valid) else $error("pc_write held longer than one cycle");
  a_flush_pulse: assert property (@(posedge clk) disable iff (rst)
    flush.valid |=> !flush.valid) else $error("flush held longer than one cycle");

  // nothing retires during the flush cycle
  a_quiet_after_flush: assert property (@(posedge clk) disable iff (rst)
    flush.valid |=> !(reg_commit.valid || store_req.valid || pd_update.valid))
    else $error("commit output after a flush cycle");

  a_one_store: assert property (@(posedge clk) disable iff (rst)
    store_req.valid |-> !store_open) else $error("second store before store_done");

endmodule

bind rob_top rob_checker u_checker (
  .clk        (clk),
  .rst        (rst),
  .fetch_en   (fetch_en),
  .decode_en  (decode_en),
  .pred_req   (pred_req),
  .pc_write   (pc_write),
  .reg_commit (reg_commit),
  .store_req  (store_req),
  .store_done (store_done),
  .pd_update  (pd_update),
  .flush      (flush)
);

// File: source/rob_top.sv
`timescale 1ns/1ps

module rob_top #(
  parameter int ROB_DEPTH = 16
) (
  input  logic                         clk,
  input  logic                         rst,
  output logic                         fetch_en,
  input  logic                         fetch_done,
  input  isa_pkg::word_t               fetch_instr,
  input  isa_pkg::addr_t               fetch_pc,
  output logic                         decode_en,
  output isa_pkg::word_t               decode_instr,
  input  logic                         dec_valid,
  input  isa_pkg::decoded_t            dec,
  output logic                         pred_req,
  input  logic                         pred_valid,
  input  logic                         pred_taken,
  output rob_pkg::redirect_t           pc_write,
  input  rob_pkg::wb_t                 exec_wb,
  input  logic [$clog2(ROB_DEPTH)-1:0] exec_tag,
  input  rob_pkg::wb_t                 mem_wb,
  input  logic [$clog2(ROB_DEPTH)-1:0] mem_tag,
  output rob_pkg::reg_commit_t         reg_commit,
  output logic [$clog2(ROB_DEPTH)-1:0] commit_tag,
  output rob_pkg::store_req_t          store_req,
  input  logic                         store_done,
  output rob_pkg::pd_update_t          pd_update,
  output rob_pkg::redirect_t           flush
);
  import rob_pkg::*;

  localparam int TAG_W = $clog2(ROB_DEPTH);

  rob_entry_t       alloc;
  logic             alloc_valid;
  logic             has_room;
  rob_entry_t       head;
  logic             head_valid;
  logic [TAG_W-1:0] head_tag;
  logic             pop;
  logic             flush_now;

  fetch_seq u_fetch_seq (
    .clk          (clk),
    .rst          (rst),
    .fetch_done   (fetch_done),
    .fetch_instr  (fetch_instr),
    .fetch_pc     (fetch_pc),
    .dec_valid    (dec_valid),
    .dec          (dec),
    .pred_valid   (pred_valid),
    .pred_taken   (pred_taken),
    .has_room     (has_room),
    .flush_now    (flush_now),
    .fetch_en     (fetch_en),
    .decode_en    (decode_en),
    .decode_instr (decode_instr),
    .pred_req     (pred_req),
    .pc_write     (pc_write),
    .alloc        (alloc),
    .alloc_valid  (alloc_valid)
  );

  // flush cycle doubles as the queue clear
  rob_store #(
    .ROB_DEPTH (ROB_DEPTH)
  ) u_rob_store (
    .clk         (clk),
    .rst         (rst),
    .alloc_valid (alloc_valid),
    .alloc       (alloc),
    .exec_wb     (exec_wb),
    .exec_tag    (exec_tag),
    .mem_wb      (mem_wb),
    .mem_tag     (mem_tag),
    .pop         (pop),
    .clear       (flush_now),
    .head        (head),
    .head_valid  (head_valid),
    .head_tag    (head_tag),
    .has_room    (has_room)
  );

  commit_unit #(
    .ROB_DEPTH (ROB_DEPTH)
  ) u_commit_unit (
    .clk        (clk),
    .rst        (rst),
    .head       (head),
    .head_valid (head_valid),
    .head_tag   (head_tag),
    .store_done (store_done),
    .pop        (pop),
    .reg_commit (reg_commit),
    .commit_tag (commit_tag),
    .store_req  (store_req),
    .pd_update  (pd_update),
    .flush      (flush),
    .flush_now  (flush_now)
  );

endmodule

// File: source/commit_unit.sv
`timescale 1ns/1ps

module commit_unit #(
  parameter int ROB_DEPTH = 16
) (
  input  logic                         clk,
  input  logic                         rst,
  input  rob_pkg::rob_entry_t          head,
  input  logic                         head_valid,
  input  logic [$clog2(ROB_DEPTH)-1:0] head_tag,
  input  logic                         store_done,
  output logic                         pop,
  output rob_pkg::reg_commit_t         reg_commit,
  output logic [$clog2(ROB_DEPTH)-1:0] commit_tag,
  output rob_pkg::store_req_t          store_req,
  output rob_pkg::pd_update_t          pd_update,
  output rob_pkg::redirect_t           flush,
  output logic                         flush_now
);
  import isa_pkg::*;

  typedef enum logic {
    C_IDLE,
    C_STORING
  } cstate_t;

  cstate_t    state;
  logic       rc_valid;
  reg_idx_t   rc_rd;
  word_t      rc_value;
  logic       sr_valid;
  addr_t      sr_addr;
  word_t      sr_data;
  logic [1:0] sr_len;
  logic       pd_valid;
  logic       pd_taken;
  logic       fl_valid;
  addr_t      fl_pc;
  logic       taken;
  logic       is_store;
  logic       is_branch;
  logic       is_jalr;

  // sb, sh, sw map to byte, halfword, word
  function automatic logic [1:0] store_len(func3_t f);
    logic [1:0] low;
    low = f[1:0];
    return (low == 2'd2) ? 2'd3 : low;
  endfunction

  assign taken     = head.result[0];
  assign is_store  = head.dec.opcode == STORE;
  assign is_branch = head.dec.opcode == BRANCH;
  assign is_jalr   = head.dec.opcode == JALR;

  // nothing retires while a store is outstanding or a flush is in progress
  assign pop = head_valid && head.ready && (state == C_IDLE) && !fl_valid;

  assign reg_commit = '{valid: rc_valid, rd: rc_rd, value: rc_value};
  assign store_req  = '{valid: sr_valid, addr: sr_addr, data: sr_data, len: sr_len};
  assign pd_update  = '{valid: pd_valid, taken: pd_taken};
  assign flush      = '{valid: fl_valid, pc: fl_pc};
  assign flush_now  = fl_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= C_IDLE;
      rc_valid <= 1'b0;
      sr_valid <= 1'b0;
      pd_valid <= 1'b0;
      fl_valid <= 1'b0;
    end else begin
      rc_valid <= 1'b0;
      sr_valid <= 1'b0;
      pd_valid <= 1'b0;
      fl_valid <= 1'b0;
      if ((state == C_STORING) && store_done) begin
        state <= C_IDLE;
      end
      if (pop) begin
        if (is_store) begin
          sr_valid <= 1'b1;
          state    <= C_STORING;
        end else if (is_branch) begin
          pd_valid <= 1'b1;
          fl_valid <= taken != head.pred;
        end else begin
          rc_valid <= head.dec.rd != '0;
          fl_valid <= is_jalr;
        end
      end
    end
  end

  // commit payloads, qualified by the valids above
  always_ff @(posedge clk) begin
    if (pop) begin
      commit_tag <= head_tag;
      rc_rd      <= head.dec.rd;
      rc_value   <= head.result;
      sr_addr    <= head.tar_addr;
      sr_data    <= head.result;
      sr_len     <= store_len(head.dec.func3);
      pd_taken   <= taken;
      if (is_branch) begin
        fl_pc <= taken ? head.pc + head.dec.imm : head.pc + INSTR_BYTES;
      end else begin
        // jalr target comes from execution
        fl_pc <= head.tar_addr;
      end
    end
  end

endmodule

// File: source/rob_store.sv
`timescale 1ns/1ps

module rob_store #(
  parameter int ROB_DEPTH = 16
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         alloc_valid,
  input  rob_pkg::rob_entry_t          alloc,
  input  rob_pkg::wb_t                 exec_wb,
  input  logic [$clog2(ROB_DEPTH)-1:0] exec_tag,
  input  rob_pkg::wb_t                 mem_wb,
  input  logic [$clog2(ROB_DEPTH)-1:0] mem_tag,
  input  logic                         pop,
  input  logic                         clear,
  output rob_pkg::rob_entry_t          head,
  output logic                         head_valid,
  output logic [$clog2(ROB_DEPTH)-1:0] head_tag,
  output logic                         has_room
);
  import rob_pkg::*;

  localparam int TAG_W = $clog2(ROB_DEPTH);

  rob_entry_t       entries [ROB_DEPTH];
  logic [TAG_W-1:0] head_ptr;
  logic [TAG_W-1:0] tail_ptr;
  logic [TAG_W-1:0] used;

  // merge a writeback into an entry
  function automatic rob_entry_t apply_wb(rob_entry_t e, wb_t wb);
    rob_entry_t r;
    r        = e;
    r.result = wb.result;
    r.ready  = 1'b1;
    if (wb.tar_valid) begin
      r.tar_addr = wb.tar_addr;
    end
    return r;
  endfunction

  // the queue never fills, so wrapping pointers give the count
  assign used       = tail_ptr - head_ptr;
  assign has_room   = used < TAG_W'(ROB_DEPTH - 1);
  assign head_valid = head_ptr != tail_ptr;
  assign head       = entries[head_ptr];
  assign head_tag   = head_ptr;

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      head_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      if (alloc_valid) begin
        tail_ptr <= tail_ptr + 1'b1;
      end
      if (pop) begin
        head_ptr <= head_ptr + 1'b1;
      end
    end
  end

  // entry contents, valid only between head and tail
  always_ff @(posedge clk) begin
    if (alloc_valid) begin
      entries[tail_ptr] <= alloc;
    end
    if (exec_wb.valid) begin
      entries[exec_tag] <= apply_wb(entries[exec_tag], exec_wb);
    end
    // later assignment, mem port wins on a shared tag
    if (mem_wb.valid) begin
      entries[mem_tag] <= apply_wb(entries[mem_tag], mem_wb);
    end
  end

endmodule

// File: source/fetch_seq.sv
`timescale 1ns/1ps

module fetch_seq (
  input  logic                clk,
  input  logic                rst,
  input  logic                fetch_done,
  input  isa_pkg::word_t      fetch_instr,
  input  isa_pkg::addr_t      fetch_pc,
  input  logic                dec_valid,
  input  isa_pkg::decoded_t   dec,
  input  logic                pred_valid,
  input  logic                pred_taken,
  input  logic                has_room,
  input  logic                flush_now,
  output logic                fetch_en,
  output logic                decode_en,
  output isa_pkg::word_t      decode_instr,
  output logic                pred_req,
  output rob_pkg::redirect_t  pc_write,
  output rob_pkg::rob_entry_t alloc,
  output logic                alloc_valid
);
  import isa_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCHING,
    S_DECODING,
    S_PREDICTING
  } state_t;

  state_t   state;
  addr_t    dec_pc;
  decoded_t br_dec;
  logic     pc_wr_valid;
  addr_t    pc_wr_pc;
  logic     dec_hit;
  logic     pred_hit;
  logic     is_branch;
  addr_t    seq_next_pc;

  assign dec_hit   = (state == S_DECODING) && dec_valid;
  assign pred_hit  = (state == S_PREDICTING) && pred_valid;
  assign is_branch = dec.opcode == BRANCH;

  // jal redirects at fetch time, everything else falls through
  assign seq_next_pc = (dec.opcode == JAL) ? dec_pc + dec.imm : dec_pc + INSTR_BYTES;

  // branches wait for their prediction before taking a slot
  assign alloc_valid = !flush_now && ((dec_hit && !is_branch) || pred_hit);

  always_comb begin
    alloc.dec      = (state == S_PREDICTING) ? br_dec : dec;
    alloc.pc       = dec_pc;
    alloc.pred     = (state == S_PREDICTING) && pred_taken;
    alloc.ready    = 1'b0;
    alloc.result   = '0;
    alloc.tar_addr = '0;
  end

  assign pc_write = '{valid: pc_wr_valid, pc: pc_wr_pc};

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_IDLE;
      fetch_en    <= 1'b0;
      decode_en   <= 1'b0;
      pred_req    <= 1'b0;
      pc_wr_valid <= 1'b0;
    end else begin
      fetch_en    <= 1'b0;
      decode_en   <= 1'b0;
      pred_req    <= 1'b0;
      pc_wr_valid <= 1'b0;
      if (flush_now) begin
        // abandon whatever is in flight
        state <= S_IDLE;
      end else begin
        case (state)
          S_IDLE: begin
            if (has_room) begin
              fetch_en <= 1'b1;
              state    <= S_FETCHING;
            end
          end
          S_FETCHING: begin
            if (fetch_done) begin
              decode_en <= 1'b1;
              state     <= S_DECODING;
            end
          end
          S_DECODING: begin
            if (dec_valid) begin
              if (is_branch) begin
                pred_req <= 1'b1;
                state    <= S_PREDICTING;
              end else begin
                pc_wr_valid <= 1'b1;
                state       <= S_IDLE;
              end
            end
          end
          S_PREDICTING: begin
            if (pred_valid) begin
              pc_wr_valid <= 1'b1;
              state       <= S_IDLE;
            end
          end
          default: state <= S_IDLE;
        endcase
      end
    end
  end

  // instruction, pc and branch fields held across the sequence
  always_ff @(posedge clk) begin
    if ((state == S_FETCHING) && fetch_done) begin
      decode_instr <= fetch_instr;
      dec_pc       <= fetch_pc;
    end
    if (dec_hit) begin
      br_dec   <= dec;
      pc_wr_pc <= seq_next_pc;
    end
    if (pred_hit) begin
      pc_wr_pc <= pred_taken ? dec_pc + br_dec.imm : dec_pc + INSTR_BYTES;
    end
  end

endmodule

// File: source/rob_pkg.sv
package rob_pkg;

  // one reorder queue entry
  typedef struct packed {
    isa_pkg::decoded_t dec;
    isa_pkg::addr_t    pc;
    logic              pred;
    logic              ready;
    isa_pkg::word_t    result;
    isa_pkg::addr_t    tar_addr;
  } rob_entry_t;

  // writeback from an execution unit, tag travels beside it
  typedef struct packed {
    logic           valid;
    isa_pkg::word_t result;
    logic           tar_valid;
    isa_pkg::addr_t tar_addr;
  } wb_t;

  // register file write at commit
  typedef struct packed {
    logic              valid;
    isa_pkg::reg_idx_t rd;
    isa_pkg::word_t    value;
  } reg_commit_t;

  // memory store, len is 0 byte, 1 halfword, 3 word
  typedef struct packed {
    logic           valid;
    isa_pkg::addr_t addr;
    isa_pkg::word_t data;
    logic [1:0]     len;
  } store_req_t;

  // new pc for the fetch unit
  typedef struct packed {
    logic           valid;
    isa_pkg::addr_t pc;
  } redirect_t;

  // branch outcome for the predictor
  typedef struct packed {
    logic valid;
    logic taken;
  } pd_update_t;

endpackage

// File: source/isa_pkg.sv
package isa_pkg;

  // basic datapath widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // architectural register number, zero means no destination
  typedef logic [4:0] reg_idx_t;

  typedef logic [2:0] func3_t;

  // major opcodes seen by the queue
  // anything not listed retires as a plain register write
  typedef enum logic [6:0] {
    LOAD   = 7'b0000011,
    OP_IMM = 7'b0010011,
    AUIPC  = 7'b0010111,
    STORE  = 7'b0100011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011,
    JALR   = 7'b1100111,
    JAL    = 7'b1101111
  } opcode_t;

  // decoder result for one instruction
  typedef struct packed {
    opcode_t  opcode;
    reg_idx_t rd;
    func3_t   func3;
    word_t    imm;
  } decoded_t;

  // sequential pc step
  localparam addr_t INSTR_BYTES = 32'd4;

endpackage
